// ==== Bender.yml ====
package:
  name: lsu_unit

sources:
  - memOpPkg.sv
  - memBusPkg.sv
  - addrAlignCheck.sv
  - storeLaneGen.sv
  - byteLaneRam.sv
  - memStageReg.sv
  - loadLaneMerge.sv
  - lsuTop.sv
  - target: test
    files:
      - lsuTop_asserts.sv
      - lsuTb.sv

// ==== addrAlignCheck.sv ====
`timescale 1ns/1ps
`default_nettype none

module addrAlignCheck
  import memOpPkg::*;
  import memBusPkg::*;
(
  input  MemReq req,
  output MemReq checked
);

  logic stMisaligned;
  logic ldMisaligned;

  // left/right forms and bytes never fault
  always_comb begin
    stMisaligned = 1'b0;
    if (req.storeType.DMWr && req.storeType.LeftOrRight == LR_NONE) begin
      if (req.storeType.size == STORETYPE_SW)
        stMisaligned = (req.addr[1:0] != 2'b00);
      else if (req.storeType.size == STORETYPE_SH)
        stMisaligned = req.addr[0];
    end
  end

  always_comb begin
    ldMisaligned = 1'b0;
    if (req.loadType.DMRd && req.loadType.LeftOrRight == LR_NONE) begin
      if (req.loadType.size == STORETYPE_SW)
        ldMisaligned = (req.addr[1:0] != 2'b00);
      else if (req.loadType.size == STORETYPE_SH)
        ldMisaligned = req.addr[0];
    end
  end

  always_comb begin
    checked = req;
    if (stMisaligned) begin
      checked.storeType.DMWr = 1'b0;  // cancel the write
      checked.exc            = EXC_ADES;
    end
    if (ldMisaligned) begin
      checked.loadType.DMRd = 1'b0;
      checked.exc           = EXC_ADEL;
    end
  end

endmodule

`default_nettype wire

// ==== byteLaneRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module byteLaneRam
  import memBusPkg::*;
#(
  parameter int ADDR_WIDTH = 6
) (
  input  logic        clk,
  input  RamCmd       cmd,
  output logic [31:0] rdata
);

  logic [31:0]           mem [2**ADDR_WIDTH];
  logic [ADDR_WIDTH-1:0] wordIdx;

  assign wordIdx = cmd.wordAddr[ADDR_WIDTH-1:0];

  always_ff @(posedge clk) begin
    for (int lane = 0; lane < 4; lane++) begin
      if (cmd.wen[lane])
        mem[wordIdx][8*lane +: 8] <= cmd.wdata[8*lane +: 8];
    end
  end

  // read-before-write on a shared address
  always_ff @(posedge clk) begin
    rdata <= mem[wordIdx];
  end

endmodule

`default_nettype wire

// ==== loadLaneMerge.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadLaneMerge
  import memOpPkg::*;
  import memBusPkg::*;
(
  input  LoadMeta     meta,
  input  logic [31:0] rdata,
  output MemResp      resp
);

  logic [31:0] shifted;
  logic [7:0]  byteVal;
  logic [15:0] halfVal;
  logic [31:0] old;

  assign shifted = rdata >> {meta.byteOff, 3'b000};
  assign byteVal = shifted[7:0];
  assign halfVal = shifted[15:0];
  assign old     = meta.regOld;

  always_comb begin
    resp.data     = old;  // stores and faults return regOld
    resp.exc      = meta.exc;
    resp.badVAddr = '0;
    if (meta.exc != EXC_NONE) begin
      resp.badVAddr = meta.addr;
    end else if (meta.loadType.DMRd) begin
      if (meta.loadType.LeftOrRight == LR_LEFT) begin  // lwl
        case (meta.byteOff)
          2'b00:   resp.data = {rdata[7:0], old[23:0]};
          2'b01:   resp.data = {rdata[15:0], old[15:0]};
          2'b10:   resp.data = {rdata[23:0], old[7:0]};
          default: resp.data = rdata;
        endcase
      end else if (meta.loadType.LeftOrRight == LR_RIGHT) begin  // lwr
        case (meta.byteOff)
          2'b00:   resp.data = rdata;
          2'b01:   resp.data = {old[31:24], rdata[31:8]};
          2'b10:   resp.data = {old[31:16], rdata[31:16]};
          default: resp.data = {old[31:8], rdata[31:24]};
        endcase
      end else begin
        case (meta.loadType.size)
          STORETYPE_SW: begin
            resp.data = rdata;
          end
          STORETYPE_SH: begin
            if (meta.loadType.signExt)
              resp.data = {{16{halfVal[15]}}, halfVal};
            else
              resp.data = {16'b0, halfVal};
          end
          STORETYPE_SB: begin
            if (meta.loadType.signExt)
              resp.data = {{24{byteVal[7]}}, byteVal};
            else
              resp.data = {24'b0, byteVal};
          end
          default: begin
            resp.data = old;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== lsuTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuTb
  import memOpPkg::*;
  import memBusPkg::*;
();

  localparam int ADDR_WIDTH = 6;
  localparam int N_WORDS    = 2**ADDR_WIDTH;
  localparam int N_BYTES    = 4*N_WORDS;
  localparam int HALF_CLK   = 4;
  localparam int N_SUBWORD  = 40;  // store/load pairs
  localparam int N_LR       = 40;
  localparam int N_FAULT    = 20;
  localparam int N_MIX      = 300;
  localparam int TOTAL_REQ  = 2*N_WORDS + 2*N_SUBWORD + 2*N_LR + 2*N_FAULT + N_MIX;
  localparam int TIMEOUT_NS = (TOTAL_REQ + 20) * 2*HALF_CLK;

  localparam int OP_SW  = 0;
  localparam int OP_SH  = 1;
  localparam int OP_SB  = 2;
  localparam int OP_SWL = 3;
  localparam int OP_SWR = 4;
  localparam int OP_LW  = 5;
  localparam int OP_LH  = 6;
  localparam int OP_LHU = 7;
  localparam int OP_LB  = 8;
  localparam int OP_LBU = 9;
  localparam int OP_LWL = 10;
  localparam int OP_LWR = 11;

  logic   clk;
  logic   rst;
  logic   reqValid;
  MemReq  req;
  logic   respValid;
  MemResp resp;

  logic [7:0] refMem [N_BYTES];  // byte-wide reference memory
  MemResp     expQ [$];
  int         errCount  = 0;
  int         testBase  = 0;
  int         reqCount  = 0;
  int         respCount = 0;

  lsuTop #(.ADDR_WIDTH(ADDR_WIDTH)) u_lsuTop (
    .clk       (clk),
    .rst       (rst),
    .reqValid  (reqValid),
    .req       (req),
    .respValid (respValid),
    .resp      (resp)
  );

  always #HALF_CLK clk = ~clk;

  task automatic checkVal(input string sigName, input logic [31:0] got,
                          input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, sigName, got, exp);
      errCount++;
    end
  endtask

  function automatic ExcCode faultOf(input MemReq r);
    ExcCode code;
    code = EXC_NONE;
    if (r.storeType.DMWr && r.storeType.LeftOrRight == LR_NONE) begin
      if ((r.storeType.size == STORETYPE_SW && r.addr[1:0] != 2'b00) ||
          (r.storeType.size == STORETYPE_SH && r.addr[0]))
        code = EXC_ADES;
    end
    if (r.loadType.DMRd && r.loadType.LeftOrRight == LR_NONE) begin
      if ((r.loadType.size == STORETYPE_SW && r.addr[1:0] != 2'b00) ||
          (r.loadType.size == STORETYPE_SH && r.addr[0]))
        code = EXC_ADEL;
    end
    return code;
  endfunction

  function automatic MemReq buildReq(input int op, input logic [31:0] addr,
                                     input logic [31:0] data, input logic [31:0] regOld);
    MemReq r;
    r           = '0;
    r.addr      = addr;
    r.storeData = data;
    r.regOld    = regOld;
    r.exc       = EXC_NONE;
    case (op)
      OP_SW:  r.storeType = '{1'b1, LR_NONE, STORETYPE_SW};
      OP_SH:  r.storeType = '{1'b1, LR_NONE, STORETYPE_SH};
      OP_SB:  r.storeType = '{1'b1, LR_NONE, STORETYPE_SB};
      OP_SWL: r.storeType = '{1'b1, LR_LEFT, STORETYPE_SW};
      OP_SWR: r.storeType = '{1'b1, LR_RIGHT, STORETYPE_SW};
      OP_LW:  r.loadType  = '{1'b1, LR_NONE, STORETYPE_SW, 1'b0};
      OP_LH:  r.loadType  = '{1'b1, LR_NONE, STORETYPE_SH, 1'b1};
      OP_LHU: r.loadType  = '{1'b1, LR_NONE, STORETYPE_SH, 1'b0};
      OP_LB:  r.loadType  = '{1'b1, LR_NONE, STORETYPE_SB, 1'b1};
      OP_LBU: r.loadType  = '{1'b1, LR_NONE, STORETYPE_SB, 1'b0};
      OP_LWL: r.loadType  = '{1'b1, LR_LEFT, STORETYPE_SW, 1'b0};
      default: r.loadType = '{1'b1, LR_RIGHT, STORETYPE_SW, 1'b0};
    endcase
    return r;
  endfunction

  // reference model, applied in issue order
  task automatic applyModel(input MemReq r);
    MemResp      exp;
    int          wb;
    int          o;
    logic [15:0] half;
    logic [7:0]  b;
    wb           = 4 * int'(r.addr[ADDR_WIDTH+1:2]);
    o            = r.addr[1:0];
    exp.data     = r.regOld;
    exp.exc      = faultOf(r);
    exp.badVAddr = '0;
    if (exp.exc != EXC_NONE) begin
      exp.badVAddr = r.addr;
    end else if (r.storeType.DMWr) begin
      if (r.storeType.LeftOrRight == LR_LEFT) begin
        for (int i = 0; i <= o; i++) refMem[wb+i] = r.storeData[8*(3-o+i) +: 8];
      end else if (r.storeType.LeftOrRight == LR_RIGHT) begin
        for (int i = o; i < 4; i++) refMem[wb+i] = r.storeData[8*(i-o) +: 8];
      end else if (r.storeType.size == STORETYPE_SW) begin
        for (int i = 0; i < 4; i++) refMem[wb+i] = r.storeData[8*i +: 8];
      end else if (r.storeType.size == STORETYPE_SH) begin
        refMem[wb+o]   = r.storeData[7:0];
        refMem[wb+o+1] = r.storeData[15:8];
      end else begin
        refMem[wb+o] = r.storeData[7:0];
      end
    end else if (r.loadType.DMRd) begin
      half = {refMem[wb+o+1-(o/3)], refMem[wb+o]};  // guard o=3, only used when even
      b    = refMem[wb+o];
      if (r.loadType.LeftOrRight == LR_LEFT) begin
        for (int i = 0; i <= o; i++) exp.data[8*(3-o+i) +: 8] = refMem[wb+i];
      end else if (r.loadType.LeftOrRight == LR_RIGHT) begin
        for (int i = o; i < 4; i++) exp.data[8*(i-o) +: 8] = refMem[wb+i];
      end else if (r.loadType.size == STORETYPE_SW) begin
        for (int i = 0; i < 4; i++) exp.data[8*i +: 8] = refMem[wb+i];
      end else if (r.loadType.size == STORETYPE_SH) begin
        exp.data = r.loadType.signExt ? {{16{half[15]}}, half} : {16'b0, half};
      end else begin
        exp.data = r.loadType.signExt ? {{24{b[7]}}, b} : {24'b0, b};
      end
    end
    expQ.push_back(exp);
  endtask

  // called on a falling edge, returns on the next one
  task automatic sendReq(input int op, input logic [31:0] addr);
    MemReq r;
    r = buildReq(op, addr, $urandom, $urandom);
    req      = r;
    reqValid = 1'b1;
    reqCount++;
    applyModel(r);
    @(negedge clk);
    reqValid = 1'b0;
  endtask

  task automatic reportTest(input string name);
    wait (respCount == reqCount);
    @(negedge clk);
    $display("%-24s %s, %0d errors", name, (errCount == testBase) ? "ok" : "failed",
             errCount - testBase);
    testBase = errCount;
  endtask

  always @(negedge clk) begin
    MemResp exp;
    if (respValid === 1'b1) begin
      if (expQ.size() == 0) begin
        $display("Response at %0t arrived with no request outstanding", $time);
        errCount++;
      end else begin
        exp = expQ.pop_front();
        checkVal("resp.data", resp.data, exp.data);
        checkVal("resp.exc", 32'(resp.exc), 32'(exp.exc));
        checkVal("resp.badVAddr", resp.badVAddr, exp.badVAddr);
      end
      respCount++;
    end else if (respValid !== 1'b0) begin
      $display("respValid is unknown at %0t", $time);
      errCount++;
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the responses did not all arrive", TIMEOUT_NS);
    $display("TB FAILED");
    $finish;
  end

  initial begin
    int          op;
    int          w;
    logic [31:0] prevAddr;
    logic        prevStore;
    int          totalErr;
    clk      = 1'b0;
    rst      = 1'b1;
    reqValid = 1'b0;
    req      = '0;
    void'($urandom(308));
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    repeat (2) begin  // idle, nothing may come out
      if (respValid !== 1'b0) begin
        $display("respValid not low after reset with no request issued");
        errCount++;
      end
      @(negedge clk);
    end
    for (int i = 0; i < N_WORDS; i++) sendReq(OP_SW, 4*i);
    for (int i = 0; i < N_WORDS; i++) sendReq(OP_LW, 4*i);
    reportTest("word store/load");

    for (int i = 0; i < N_SUBWORD; i++) begin
      w  = $urandom_range(0, N_WORDS-1);
      op = $urandom_range(OP_SH, OP_SB);
      sendReq(op, 4*w + (op == OP_SH ? 2*$urandom_range(0, 1) : $urandom_range(0, 3)));
      op = $urandom_range(OP_LH, OP_LBU);
      sendReq(op, 4*w + (op <= OP_LHU ? 2*$urandom_range(0, 1) : $urandom_range(0, 3)));
    end
    reportTest("byte/half store/load");

    for (int i = 0; i < N_LR; i++) begin
      w = $urandom_range(0, N_WORDS-1);
      sendReq(OP_SWL + (i / 4) % 2, 4*w + (i % 4));  // swl then swr, every offset
      sendReq(OP_LWL + (i / 8) % 2, 4*w + (i / 2) % 4);
    end
    reportTest("left/right store/load");

    for (int i = 0; i < N_FAULT; i++) begin
      w = $urandom_range(0, N_WORDS-1);
      case ($urandom_range(0, 4))
        0: sendReq(OP_SH, 4*w + 2*$urandom_range(0, 1) + 1);
        1: sendReq(OP_SW, 4*w + $urandom_range(1, 3));
        2: sendReq(OP_LH, 4*w + 2*$urandom_range(0, 1) + 1);
        3: sendReq(OP_LHU, 4*w + 2*$urandom_range(0, 1) + 1);
        default: sendReq(OP_LW, 4*w + $urandom_range(1, 3));
      endcase
      sendReq(OP_LW, 4*w);  // memory must be untouched
    end
    reportTest("misaligned access");

    prevStore = 1'b0;
    prevAddr  = '0;
    for (int i = 0; i < N_MIX; i++) begin
      op = $urandom_range(OP_SW, OP_LWR);
      w  = $urandom_range(0, N_BYTES-1);
      if (prevStore && $urandom_range(0, 1)) begin  // load hits the word just stored
        op = $urandom_range(OP_LW, OP_LWR);
        w  = {prevAddr[31:2], 2'(($urandom_range(0, 3)))};
      end
      prevStore = (op <= OP_SWR);
      prevAddr  = w;
      sendReq(op, w);
    end
    reportTest("back-to-back mix");

    totalErr = errCount + u_lsuTop.u_lsuTopAsserts.failCount;
    if (reqCount != respCount || expQ.size() != 0) begin
      $display("Request and response counts differ at the end of the run");
      totalErr++;
    end
    $display("Requests %0d, responses %0d, check errors %0d, assertion failures %0d",
             reqCount, respCount, errCount, u_lsuTop.u_lsuTopAsserts.failCount);
    if (totalErr == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== lsuTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuTop
  import memBusPkg::*;
#(
  parameter int ADDR_WIDTH = 6
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   reqValid,
  input  MemReq  req,
  output logic   respValid,
  output MemResp resp
);

  MemReq       checkedReq;
  logic        stageAValid;
  MemReq       stageAReq;
  RamCmd       ramCmd;
  logic [31:0] ramRdata;
  LoadMeta     metaIn;
  LoadMeta     stageBMeta;

  addrAlignCheck u_alignCheck (
    .req     (req),
    .checked (checkedReq)
  );

  memStageReg #(.T(MemReq)) u_stageA (
    .clk      (clk),
    .rst      (rst),
    .inValid  (reqValid),
    .inData   (checkedReq),
    .outValid (stageAValid),
    .outData  (stageAReq)
  );

  storeLaneGen u_storeLaneGen (
    .req    (stageAReq),
    .ramCmd (ramCmd)
  );

  // gate by stage A valid, payload regs hold stale requests
  RamCmd ramCmdGated;
  always_comb begin
    ramCmdGated     = ramCmd;
    ramCmdGated.wen = stageAValid ? ramCmd.wen : 4'b0000;
  end

  byteLaneRam #(.ADDR_WIDTH(ADDR_WIDTH)) u_ram (
    .clk   (clk),
    .cmd   (ramCmdGated),
    .rdata (ramRdata)
  );

  assign metaIn.byteOff  = stageAReq.addr[1:0];
  assign metaIn.loadType = stageAReq.loadType;
  assign metaIn.regOld   = stageAReq.regOld;
  assign metaIn.addr     = stageAReq.addr;
  assign metaIn.exc      = stageAReq.exc;

  memStageReg #(.T(LoadMeta)) u_stageB (
    .clk      (clk),
    .rst      (rst),
    .inValid  (stageAValid),
    .inData   (metaIn),
    .outValid (respValid),
    .outData  (stageBMeta)
  );

  loadLaneMerge u_loadLaneMerge (
    .meta  (stageBMeta),
    .rdata (ramRdata),
    .resp  (resp)
  );

endmodule

`default_nettype wire

// ==== lsuTop_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsuTop_asserts
  import memOpPkg::*;
  import memBusPkg::*;
(
  input wire logic  clk,
  input wire logic  rst,
  input wire logic  reqValid,
  input wire logic  respValid,
  input wire logic  stageAValid,
  input wire MemReq stageAReq,
  input wire RamCmd ramCmd
);

  int failCount = 0;

  quietInReset: assert property (@(posedge clk) rst |=> !respValid)
    else begin $error("respValid high during reset"); failCount++; end

  quietAfterReset: assert property (@(posedge clk) $fell(rst) |-> !respValid ##1 !respValid)
    else begin $error("respValid high right after reset"); failCount++; end

  twoCycleLatency: assert property (@(posedge clk) disable iff (rst)
                                    reqValid |-> ##2 respValid)
    else begin $error("no response two cycles after request"); failCount++; end

  noSpuriousResp: assert property (@(posedge clk) disable iff (rst)
                                   respValid |-> $past(reqValid, 2))
    else begin $error("response without request two cycles before"); failCount++; end

  // empty stage, load or faulted request
  noWriteWhenIdle: assert property (@(posedge clk)
                                    !stageAValid || stageAReq.loadType.DMRd ||
                                    stageAReq.exc != EXC_NONE
                                    |-> ramCmd.wen == 4'b0000)
    else begin $error("ram write enable active without a valid store in stage A"); failCount++; end

endmodule

bind lsuTop lsuTop_asserts u_lsuTopAsserts (
  .clk         (clk),
  .rst         (rst),
  .reqValid    (reqValid),
  .respValid   (respValid),
  .stageAValid (stageAValid),
  .stageAReq   (stageAReq),
  .ramCmd      (ramCmdGated)
);

`default_nettype wire

// ==== memBusPkg.sv ====
`default_nettype none

package memBusPkg;

  import memOpPkg::*;

  // request as it travels down the pipe
  typedef struct packed {
    logic [31:0] addr;
    StoreType    storeType;
    LoadType     loadType;
    logic [31:0] storeData;
    logic [31:0] regOld;     // old rt value, for lwl/lwr merge
    ExcCode      exc;
  } MemReq;

  typedef struct packed {
    logic [3:0]  wen;
    logic [31:0] wdata;
    logic [31:0] wordAddr;  // ram keeps only the low bits
  } RamCmd;

  // load context, registered alongside the ram read
  typedef struct packed {
    logic [1:0]  byteOff;
    LoadType     loadType;
    logic [31:0] regOld;
    logic [31:0] addr;
    ExcCode      exc;
  } LoadMeta;

  typedef struct packed {
    logic [31:0] data;
    ExcCode      exc;
    logic [31:0] badVAddr;
  } MemResp;

endpackage

`default_nettype wire

// ==== memOpPkg.sv ====
`default_nettype none

package memOpPkg;

  // size codes of StoreType / LoadType
  localparam logic [1:0] STORETYPE_SW = 2'b00;
  localparam logic [1:0] STORETYPE_SH = 2'b01;
  localparam logic [1:0] STORETYPE_SB = 2'b10;

  // LeftOrRight codes, shared by swl/swr and lwl/lwr
  localparam logic [1:0] LR_NONE  = 2'b00;
  localparam logic [1:0] LR_RIGHT = 2'b01;
  localparam logic [1:0] LR_LEFT  = 2'b10;

  typedef struct packed {
    logic       DMWr;         // write request
    logic [1:0] LeftOrRight;  // 10 swl, 01 swr
    logic [1:0] size;
  } StoreType;

  typedef struct packed {
    logic       DMRd;         // read request
    logic [1:0] LeftOrRight;  // 10 lwl, 01 lwr
    logic [1:0] size;
    logic       signExt;      // lh/lb vs lhu/lbu
  } LoadType;

  typedef enum logic [1:0] {
    EXC_NONE = 2'b00,
    EXC_ADEL = 2'b01,  // load address error
    EXC_ADES = 2'b10   // store address error
  } ExcCode;

endpackage

`default_nettype wire

// ==== memStageReg.sv ====
`timescale 1ns/1ps
`default_nettype none

module memStageReg #(
  parameter type T = logic [31:0]
) (
  input  logic clk,
  input  logic rst,
  input  logic inValid,
  input  T     inData,
  output logic outValid,
  output T     outData
);

  always_ff @(posedge clk) begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= inValid;
  end

  always_ff @(posedge clk) begin
    if (inValid)
      outData <= inData;  // payload held otherwise
  end

endmodule

`default_nettype wire

// ==== sim.f ====
memOpPkg.sv
memBusPkg.sv
addrAlignCheck.sv
storeLaneGen.sv
byteLaneRam.sv
memStageReg.sv
loadLaneMerge.sv
lsuTop.sv
lsuTop_asserts.sv
lsuTb.sv

// ==== storeLaneGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module storeLaneGen
  import memOpPkg::*;
  import memBusPkg::*;
(
  input  MemReq req,
  output RamCmd ramCmd
);

  logic [1:0]  byteOff;
  logic [31:0] rt;

  assign byteOff         = req.addr[1:0];
  assign rt              = req.storeData;
  assign ramCmd.wordAddr = {2'b00, req.addr[31:2]};

  always_comb begin
    ramCmd.wen   = 4'b0000;
    ramCmd.wdata = '0;
    if (req.storeType.DMWr) begin
      if (req.storeType.LeftOrRight == LR_LEFT) begin  // swl
        case (byteOff)
          2'b00: begin
            ramCmd.wen   = 4'b0001;
            ramCmd.wdata = {24'b0, rt[31:24]};
          end
          2'b01: begin
            ramCmd.wen   = 4'b0011;
            ramCmd.wdata = {16'b0, rt[31:16]};
          end
          2'b10: begin
            ramCmd.wen   = 4'b0111;
            ramCmd.wdata = {8'b0, rt[31:8]};
          end
          default: begin
            ramCmd.wen   = 4'b1111;
            ramCmd.wdata = rt;
          end
        endcase
      end else if (req.storeType.LeftOrRight == LR_RIGHT) begin  // swr
        case (byteOff)
          2'b00: begin
            ramCmd.wen   = 4'b1111;
            ramCmd.wdata = rt;
          end
          2'b01: begin
            ramCmd.wen   = 4'b1110;
            ramCmd.wdata = {rt[23:0], 8'b0};
          end
          2'b10: begin
            ramCmd.wen   = 4'b1100;
            ramCmd.wdata = {rt[15:0], 16'b0};
          end
          default: begin
            ramCmd.wen   = 4'b1000;
            ramCmd.wdata = {rt[7:0], 24'b0};
          end
        endcase
      end else begin
        case (req.storeType.size)
          STORETYPE_SW: begin
            ramCmd.wen   = 4'b1111;
            ramCmd.wdata = rt;
          end
          STORETYPE_SH: begin
            ramCmd.wen   = byteOff[1] ? 4'b1100 : 4'b0011;
            ramCmd.wdata = {rt[15:0], rt[15:0]};  // both halves, wen picks
          end
          STORETYPE_SB: begin
            ramCmd.wen   = 4'b0001 << byteOff;
            ramCmd.wdata = {4{rt[7:0]}};
          end
          default: begin
            ramCmd.wen   = 4'b0000;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire
